// ==== rp_sysbus_pkg.sv ====
/*
 * Shared definitions for the system bus interconnect and the DAC summing stage.
 * Holds the bus word types, the address map of the configuration bank and the
 * per-region interrupt configuration words. Modules refer to these by scoped
 * names, e.g. rp_sysbus_pkg::sys_data_t.
 */
package rp_sysbus_pkg;

  // --------------------------------------------------
  // bus words and address map

  typedef logic [31:0] sys_addr_t;  // system bus address
  typedef logic [31:0] sys_data_t;  // system bus read word

  localparam int region_field_hi = 29;  // region field, 10 bits
  localparam int region_field_lo = 20;

  localparam logic [9:0]  sysconf_bank        = 10'h3ff;      // config bank region
  localparam sys_data_t   sysconf_id          = 32'hfff00002; // class fff, version 00002
  localparam logic [19:0] sysconf_id_ofs      = 20'hf0000;
  localparam logic [19:0] sysconf_regions_ofs = 20'hf0004;
  localparam logic [19:0] sysconf_irq_ofs     = 20'hf0100; // + 4 per region

  localparam int irq_lines   = 16;  // width of irq vector to the processor
  localparam int max_regions = 8;   // entries in the irq config table

  // --------------------------------------------------
  // interrupt configuration word

  typedef struct packed {
    logic [11:0] rsvd;    // reads as zero
    logic        en_l0;   // enable line 0
    logic        en_l1;
    logic        en_l2;
    logic        en_l3;
    logic [3:0]  num_l0;  // irq number for line 0
    logic [3:0]  num_l1;
    logic [3:0]  num_l2;
    logic [3:0]  num_l3;
  } irq_cfg_s;

  typedef union packed {
    sys_data_t raw;  // as returned on the bus
    irq_cfg_s  cfg;  // as decoded by the router
  } irq_cfg_u;

  // one word per region, only line 0 is ever enabled
  localparam irq_cfg_u irq_cfg_table [max_regions] = '{
    32'h0008_a000,  // region 0: line 0 -> irq 10
    32'h0008_4000,  // region 1: line 0 -> irq 4
    32'h0000_0000,
    32'h0000_0000,
    32'h0000_0000,
    32'h0000_0000,
    32'h0000_0000,
    32'h0000_0000
  };

endpackage

// ==== bus_decoder.sv ====
/*
 * System bus address decoder.
 * Splits the address region field into a one-hot region select and a separate
 * select for the configuration bank. The per-region write and read strobes are
 * the select gated with the bus enables. Purely combinational.
 */
`timescale 1ns/1ps

module bus_decoder #(
  parameter int num_regions_p = 8  // decoded regions
) (
  input  rp_sysbus_pkg::sys_addr_t  sys_addr_i,    // bus address
  input  logic                      sys_wen_i,     // bus write enable
  input  logic                      sys_ren_i,     // bus read enable
  output logic [num_regions_p-1:0]  region_cs_o,   // one-hot region select
  output logic                      sysconf_cs_o,  // config bank select
  output logic [num_regions_p-1:0]  region_wen_o,  // per-region write strobe
  output logic [num_regions_p-1:0]  region_ren_o   // per-region read strobe
);

  localparam int field_w_lp =
    rp_sysbus_pkg::region_field_hi - rp_sysbus_pkg::region_field_lo + 1;

  logic [field_w_lp-1:0] region_field;  // address bits 29:20

  assign region_field =
    sys_addr_i[rp_sysbus_pkg::region_field_hi:rp_sysbus_pkg::region_field_lo];

  // --------------------------------------------------
  // region and bank selects

  always_comb begin
    region_cs_o = '0;
    for (int r = 0; r < num_regions_p; r++) begin
      if (region_field == field_w_lp'(r)) begin
        region_cs_o[r] = 1'b1;  // at most one match
      end
    end
  end

  assign sysconf_cs_o = (region_field == rp_sysbus_pkg::sysconf_bank);  // top of map

  // --------------------------------------------------
  // strobes, zero whenever the bus is idle

  assign region_wen_o = region_cs_o & {num_regions_p{sys_wen_i}};
  assign region_ren_o = region_cs_o & {num_regions_p{sys_ren_i}};

endmodule

// ==== response_mux.sv ====
/*
 * Read channel multiplexer of the system bus.
 * Each bit line ORs the selected region's bit with the config bank's bit.
 * Regions at and above first_free_p have no block behind them and answer with
 * ack 1, err 0 and zero data. Nothing selected gives all zero.
 */
`timescale 1ns/1ps

module response_mux #(
  parameter int num_regions_p = 8,  // decoded regions
  parameter int first_free_p  = 6   // first region without a block
) (
  input  logic [num_regions_p-1:0]                     region_cs_i,
  input  logic                                         sysconf_cs_i,
  input  rp_sysbus_pkg::sys_data_t [first_free_p-1:0]  region_rdata_i,
  input  logic [first_free_p-1:0]                      region_ack_i,
  input  logic [first_free_p-1:0]                      region_err_i,
  input  rp_sysbus_pkg::sys_data_t                     sysconf_rdata_i,
  output rp_sysbus_pkg::sys_data_t                     sys_rdata_o,
  output logic                                         sys_ack_o,
  output logic                                         sys_err_o
);

  localparam int data_w_lp = $bits(rp_sysbus_pkg::sys_data_t);

  rp_sysbus_pkg::sys_data_t [num_regions_p-1:0] rdata_all;  // every region, filled
  logic [num_regions_p-1:0] ack_all;
  logic [num_regions_p-1:0] err_all;

  // --------------------------------------------------
  // mapped regions from ports, free ones fixed

  for (genvar r = 0; r < num_regions_p; r++) begin : g_region
    if (r < first_free_p) begin : g_mapped
      assign rdata_all[r] = region_rdata_i[r];
      assign ack_all[r]   = region_ack_i[r];
      assign err_all[r]   = region_err_i[r];
    end else begin : g_free
      assign rdata_all[r] = '0;    // reads as zero
      assign ack_all[r]   = 1'b1;  // never stalls the master
      assign err_all[r]   = 1'b0;
    end
  end

  // --------------------------------------------------
  // per bit line: gather bit b of all regions, mask by select

  for (genvar b = 0; b < data_w_lp; b++) begin : g_bit
    logic [num_regions_p-1:0] bit_line;  // bit b across regions
    for (genvar r = 0; r < num_regions_p; r++) begin : g_gather
      assign bit_line[r] = rdata_all[r][b];
    end
    assign sys_rdata_o[b] = |(region_cs_i & bit_line) | (sysconf_cs_i & sysconf_rdata_i[b]);
  end

  assign sys_ack_o = |(region_cs_i & ack_all) | sysconf_cs_i;  // bank always acks
  assign sys_err_o = |(region_cs_i & err_all);                 // bank never errs

endmodule

// ==== sysconf_rom.sv ====
/*
 * Read-only configuration bank of the system bus.
 * The driver reads the device ID, the number of regions and one interrupt
 * configuration word per region from here. Only the low 20 address bits are
 * decoded; the bank select itself comes from the bus decoder.
 */
`timescale 1ns/1ps

module sysconf_rom #(
  parameter int num_regions_p = 8  // regions reported to the driver
) (
  input  rp_sysbus_pkg::sys_addr_t  sys_addr_i,      // bus address
  output rp_sysbus_pkg::sys_data_t  sysconf_rdata_o  // bank read word
);

  localparam int ofs_w_lp = rp_sysbus_pkg::region_field_lo;  // 20 bit offset

  logic [ofs_w_lp-1:0] bank_ofs;  // offset within the bank

  assign bank_ofs = sys_addr_i[ofs_w_lp-1:0];  // region field ignored here

  // --------------------------------------------------
  // offset decode

  always_comb begin
    sysconf_rdata_o = '0;  // unused offsets read zero
    if (bank_ofs == rp_sysbus_pkg::sysconf_id_ofs) begin
      sysconf_rdata_o = rp_sysbus_pkg::sysconf_id;
    end else if (bank_ofs == rp_sysbus_pkg::sysconf_regions_ofs) begin
      sysconf_rdata_o = 32'(num_regions_p);  // region count
    end else begin
      // irq config words, 4 bytes apart
      for (int r = 0; r < num_regions_p; r++) begin
        if (bank_ofs == rp_sysbus_pkg::sysconf_irq_ofs + ofs_w_lp'(4 * r)) begin
          sysconf_rdata_o = rp_sysbus_pkg::irq_cfg_table[r].raw;
        end
      end
    end
  end

  /*
   * word layout, one per region:
   *   31..20 reserved
   *   19..16 enable for line 0, 1, 2, 3
   *   15..0  irq number of line 0 .. line 3, a nibble each
   */

endmodule

// ==== irq_router.sv ====
/*
 * Interrupt router between the bus regions and the processor.
 * Each mapped region drives its line-0 request onto the vector bit named in
 * its configuration word, if that line is enabled. Requests sharing a number
 * are ORed. The vector is registered, so it lags the requests by one cycle.
 */
`timescale 1ns/1ps

module irq_router #(
  parameter int num_regions_p = 8,  // decoded regions
  parameter int first_free_p  = 6   // regions with a block, and an irq
) (
  input  logic                                  adc_clk,
  input  logic                                  rst_i,        // sync, active high
  input  logic [first_free_p-1:0]               region_irq_i, // line 0 per region
  output logic [rp_sysbus_pkg::irq_lines-1:0]   irq_f2p_o     // to processor
);

  localparam int routed_lp = (first_free_p < num_regions_p) ? first_free_p : num_regions_p;

  logic [rp_sysbus_pkg::irq_lines-1:0] irq_next;  // routed, before the register

  // --------------------------------------------------
  // routing from the config table

  always_comb begin
    rp_sysbus_pkg::irq_cfg_u cfg_word;  // word of the current region
    cfg_word = '0;
    irq_next = '0;
    for (int r = 0; r < routed_lp; r++) begin
      cfg_word = rp_sysbus_pkg::irq_cfg_table[r];
      if (cfg_word.cfg.en_l0) begin  // lines 1..3 unused
        irq_next[cfg_word.cfg.num_l0] = irq_next[cfg_word.cfg.num_l0] | region_irq_i[r];
      end
    end
  end

  // --------------------------------------------------
  // output register

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      irq_f2p_o <= '0;
    end else begin
      irq_f2p_o <= irq_next;  // one cycle behind the requests
    end
  end

endmodule

// ==== dac_mixer.sv ====
/*
 * One DAC channel: sum of the signal generator and controller samples.
 * The sum is one bit wider than the samples; its two top bits flag overflow
 * and the result is clamped to the full-scale code. Registered output, so
 * the DAC sample follows the inputs by one cycle.
 */
`timescale 1ns/1ps

module dac_mixer #(
  parameter int dac_width_p = 14  // DAC sample width
) (
  input  logic                           adc_clk,
  input  logic                           rst_i,    // sync, active high
  input  logic signed [dac_width_p-1:0]  gen_i,    // generator sample
  input  logic signed [dac_width_p-1:0]  ctrl_i,   // controller sample
  output logic signed [dac_width_p-1:0]  dac_o     // clamped sum
);

  localparam logic [dac_width_p-1:0] pos_max_lp = {1'b0, {(dac_width_p-1){1'b1}}};  // 0x1fff
  localparam logic [dac_width_p-1:0] neg_min_lp = {1'b1, {(dac_width_p-1){1'b0}}};  // 0x2000

  logic signed [dac_width_p:0]    sum;  // one guard bit
  logic signed [dac_width_p-1:0]  sat;  // clamped, before the register

  assign sum = gen_i + ctrl_i;  // sign extended by context

  // --------------------------------------------------
  // saturation on the two top bits

  always_comb begin
    case (sum[dac_width_p:dac_width_p-1])
      2'b01:   sat = pos_max_lp;  // pos. overflow
      2'b10:   sat = neg_min_lp;  // neg. overflow
      default: sat = sum[dac_width_p-1:0];
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      dac_o <= '0;
    end else begin
      dac_o <= sat;
    end
  end

endmodule

// ==== rp_sysbus_top.sv ====
/*
 * Top level of the system bus interconnect and the DAC summing stage.
 * The bus master drives address and enables; the regions appear as ports.
 * Bus responses are combinational, the interrupt vector and the DAC samples
 * are registered once. Sets the parameters for all blocks below.
 */
`timescale 1ns/1ps

module rp_sysbus_top #(
  parameter int num_regions_p = 8,   // decoded regions
  parameter int first_free_p  = 6,   // first region without a block
  parameter int dac_width_p   = 14   // DAC sample width
) (
  input  logic                                         adc_clk,
  input  logic                                         rst_i,          // sync, active high

  // bus master
  input  rp_sysbus_pkg::sys_addr_t                     sys_addr_i,
  input  logic                                         sys_wen_i,
  input  logic                                         sys_ren_i,
  output rp_sysbus_pkg::sys_data_t                     sys_rdata_o,
  output logic                                         sys_ack_o,
  output logic                                         sys_err_o,

  // regions
  output logic [num_regions_p-1:0]                     region_wen_o,
  output logic [num_regions_p-1:0]                     region_ren_o,
  input  rp_sysbus_pkg::sys_data_t [first_free_p-1:0]  region_rdata_i,
  input  logic [first_free_p-1:0]                      region_ack_i,
  input  logic [first_free_p-1:0]                      region_err_i,
  input  logic [first_free_p-1:0]                      region_irq_i,

  // interrupts to the processor
  output logic [rp_sysbus_pkg::irq_lines-1:0]          irq_f2p_o,

  // DAC samples
  input  logic signed [dac_width_p-1:0]                asg_a_i,        // generator ch a
  input  logic signed [dac_width_p-1:0]                asg_b_i,        // generator ch b
  input  logic signed [dac_width_p-1:0]                pid_a_i,        // controller ch a
  input  logic signed [dac_width_p-1:0]                pid_b_i,        // controller ch b
  output logic signed [dac_width_p-1:0]                dac_a_o,
  output logic signed [dac_width_p-1:0]                dac_b_o
);

  logic [num_regions_p-1:0]  region_cs;      // one-hot region select
  logic                      sysconf_cs;     // config bank select
  rp_sysbus_pkg::sys_data_t  sysconf_rdata;  // bank word

  // --------------------------------------------------
  // system bus

  bus_decoder #(
    .num_regions_p (num_regions_p)
  ) u_bus_decoder (
    .sys_addr_i    (sys_addr_i),
    .sys_wen_i     (sys_wen_i),
    .sys_ren_i     (sys_ren_i),
    .region_cs_o   (region_cs),
    .sysconf_cs_o  (sysconf_cs),
    .region_wen_o  (region_wen_o),
    .region_ren_o  (region_ren_o)
  );

  sysconf_rom #(
    .num_regions_p   (num_regions_p)
  ) u_sysconf_rom (
    .sys_addr_i      (sys_addr_i),
    .sysconf_rdata_o (sysconf_rdata)
  );

  response_mux #(
    .num_regions_p   (num_regions_p),
    .first_free_p    (first_free_p)
  ) u_response_mux (
    .region_cs_i     (region_cs),
    .sysconf_cs_i    (sysconf_cs),
    .region_rdata_i  (region_rdata_i),
    .region_ack_i    (region_ack_i),
    .region_err_i    (region_err_i),
    .sysconf_rdata_i (sysconf_rdata),
    .sys_rdata_o     (sys_rdata_o),
    .sys_ack_o       (sys_ack_o),
    .sys_err_o       (sys_err_o)
  );

  // --------------------------------------------------
  // interrupts

  irq_router #(
    .num_regions_p (num_regions_p),
    .first_free_p  (first_free_p)
  ) u_irq_router (
    .adc_clk       (adc_clk),
    .rst_i         (rst_i),
    .region_irq_i  (region_irq_i),
    .irq_f2p_o     (irq_f2p_o)
  );

  // --------------------------------------------------
  // DAC summing, one mixer per channel

  dac_mixer #(
    .dac_width_p (dac_width_p)
  ) u_dac_mixer_a (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .gen_i       (asg_a_i),
    .ctrl_i      (pid_a_i),
    .dac_o       (dac_a_o)
  );

  dac_mixer #(
    .dac_width_p (dac_width_p)
  ) u_dac_mixer_b (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .gen_i       (asg_b_i),
    .ctrl_i      (pid_b_i),
    .dac_o       (dac_b_o)
  );

endmodule

// ==== tb_clock_gen.sv ====
/*
 * Clock and reset source for the testbench.
 * adc_clk toggles every half period; reset is held high for a number of
 * clock cycles and released on a falling edge.
 */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int period_ns_p    = 100,  // adc_clk period
  parameter int reset_cycles_p = 2     // rising edges under reset
) (
  output logic adc_clk_o,
  output logic rst_o      // sync, active high
);

  initial begin
    adc_clk_o = 1'b0;
    forever #(period_ns_p / 2) adc_clk_o = ~adc_clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (reset_cycles_p) @(posedge adc_clk_o);
    @(negedge adc_clk_o);  // release away from the sampling edge
    rst_o = 1'b0;
  end

endmodule

// ==== tb_rp_sysbus.sv ====
/*
 * Testbench for the system bus interconnect and the DAC summing stage.
 * Inputs change on the falling edge; concurrent assertions on the rising
 * edge compare the DUT against reference rules for decode, read response,
 * configuration bank, interrupt routing and DAC saturation.
 */
`timescale 1ns/1ps

module tb_rp_sysbus;

  localparam int num_regions_lp = 8;
  localparam int first_free_lp  = 6;
  localparam int dac_w_lp       = 14;

  logic                      adc_clk;
  logic                      rst_i;
  logic [31:0]               sys_addr;
  logic                      sys_wen;
  logic                      sys_ren;
  logic [31:0]               sys_rdata;
  logic                      sys_ack;
  logic                      sys_err;
  logic [7:0]                region_wen;
  logic [7:0]                region_ren;
  logic [5:0][31:0]          region_rdata;  // one word per mapped region
  logic [5:0]                region_ack;
  logic [5:0]                region_err;
  logic [5:0]                region_irq;
  logic [15:0]               irq_f2p;
  logic signed [13:0]        asg_a, asg_b, pid_a, pid_b;
  logic signed [13:0]        dac_a, dac_b;
  integer                    seed;

  tb_clock_gen #(.period_ns_p(100), .reset_cycles_p(2)) u_clock_gen (
    .adc_clk_o (adc_clk),
    .rst_o     (rst_i)
  );

  rp_sysbus_top #(
    .num_regions_p (num_regions_lp),
    .first_free_p  (first_free_lp),
    .dac_width_p   (dac_w_lp)
  ) uut (
    .adc_clk (adc_clk), .rst_i (rst_i),
    .sys_addr_i (sys_addr), .sys_wen_i (sys_wen), .sys_ren_i (sys_ren),
    .sys_rdata_o (sys_rdata), .sys_ack_o (sys_ack), .sys_err_o (sys_err),
    .region_wen_o (region_wen), .region_ren_o (region_ren),
    .region_rdata_i (region_rdata), .region_ack_i (region_ack),
    .region_err_i (region_err), .region_irq_i (region_irq),
    .irq_f2p_o (irq_f2p),
    .asg_a_i (asg_a), .asg_b_i (asg_b), .pid_a_i (pid_a), .pid_b_i (pid_b),
    .dac_a_o (dac_a), .dac_b_o (dac_b)
  );

  // --------------------------------------------------
  // failure reporting

  task automatic report_mismatch(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic report_timeout(input string msg);
    $display("timeout: %s", msg);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  // --------------------------------------------------
  // reference rules

  function automatic logic [7:0] strobe_for(input logic [31:0] addr, input logic en);
    logic [9:0] field;
    field = addr[29:20];
    if (!en || field >= 10'd8) return 8'h00;  // idle bus or no region
    return 8'h01 << field[2:0];
  endfunction

  function automatic logic [31:0] bank_word(input logic [19:0] ofs);
    case (ofs)
      20'hf0000: return 32'hfff0_0002;                       // device id
      20'hf0004: return 32'd8;                               // region count
      20'hf0100: return {12'h000, 4'b1000, 4'd10, 12'h000};  // region 0 line 0 to irq 10
      20'hf0104: return {12'h000, 4'b1000, 4'd4, 12'h000};   // region 1 line 0 to irq 4
      default:   return 32'h0;
    endcase
  endfunction

  // {ack, err, rdata} as the master should see it
  function automatic logic [33:0] response_for(input logic [31:0] addr,
      input logic [5:0][31:0] rd, input logic [5:0] ack, input logic [5:0] err);
    logic [9:0] field;
    int         idx;
    field = addr[29:20];
    idx   = int'(field);
    if (field == 10'h3ff) return {1'b1, 1'b0, bank_word(addr[19:0])};
    if (idx < 6) return {ack[idx], err[idx], rd[idx]};
    if (idx < 8) return {1'b1, 1'b0, 32'h0};  // unmapped but decoded
    return 34'h0;
  endfunction

  function automatic logic [15:0] routed_irq(input logic [5:0] irq);
    logic [15:0] v;
    v     = 16'h0;
    v[10] = irq[0];
    v[4]  = irq[1];
    return v;
  endfunction

  function automatic logic [13:0] clamp_sum(input logic signed [13:0] a,
      input logic signed [13:0] b);
    int s;
    s = int'(a) + int'(b);
    if (s > 8191) return 14'h1fff;
    if (s < -8192) return 14'h2000;
    return s[13:0];
  endfunction

  // --------------------------------------------------
  // checks sampled on the rising edge

  a_strobes: assert property (@(posedge adc_clk) disable iff (rst_i)
      region_wen == strobe_for(sys_addr, sys_wen) && region_ren == strobe_for(sys_addr, sys_ren))
    else report_mismatch($sformatf("region strobes wrong for address %h", sys_addr));

  a_response: assert property (@(posedge adc_clk) disable iff (rst_i)
      {sys_ack, sys_err, sys_rdata} ==
        response_for(sys_addr, region_rdata, region_ack, region_err))
    else report_mismatch($sformatf("bus response wrong for address %h", sys_addr));

  a_irq: assert property (@(posedge adc_clk) disable iff (rst_i)
      irq_f2p == ($past(rst_i) ? 16'h0 : routed_irq($past(region_irq))))
    else report_mismatch($sformatf("irq vector %h not as routed", irq_f2p));

  a_dac_a: assert property (@(posedge adc_clk) disable iff (rst_i)
      dac_a == ($past(rst_i) ? 14'h0 : clamp_sum($past(asg_a), $past(pid_a))))
    else report_mismatch($sformatf("dac_a %h not the clamped sum", dac_a));

  a_dac_b: assert property (@(posedge adc_clk) disable iff (rst_i)
      dac_b == ($past(rst_i) ? 14'h0 : clamp_sum($past(asg_b), $past(pid_b))))
    else report_mismatch($sformatf("dac_b %h not the clamped sum", dac_b));

  // --------------------------------------------------
  // stimulus

  task automatic wait_reset_release(input int limit);
    int n;
    n = 0;
    while (rst_i !== 1'b0 && n < limit) begin
      @(posedge adc_clk);  // reset moves on the falling edge
      n++;
    end
    if (rst_i !== 1'b0) report_timeout("reset was still asserted after the wait limit");
  endtask

  task automatic randomize_regions();
    logic [31:0] rnd;
    for (int i = 0; i < 6; i++) region_rdata[i] = $random(seed);
    rnd        = $random(seed);
    region_ack = rnd[5:0];
    region_err = rnd[11:6];
    region_irq = rnd[17:12];
    rnd        = $random(seed);
    asg_a      = rnd[13:0];
    pid_a      = rnd[27:14];
    rnd        = $random(seed);
    asg_b      = rnd[13:0];
    pid_b      = rnd[27:14];
  endtask

  // one bus cycle with fresh region responses and samples
  task automatic access(input logic [9:0] field, input logic [19:0] ofs,
      input logic wen, input logic ren);
    @(negedge adc_clk);
    randomize_regions();
    sys_addr = {2'b00, field, ofs};
    sys_wen  = wen;
    sys_ren  = ren;
  endtask

  task automatic drive_dac(input int a_a, input int p_a, input int a_b, input int p_b);
    @(negedge adc_clk);
    asg_a = 14'(a_a);
    pid_a = 14'(p_a);
    asg_b = 14'(a_b);
    pid_b = 14'(p_b);
  endtask

  initial begin
    logic [31:0] rnd;
    logic [9:0]  field;
    seed         = 32'hdf50_0d6b;
    sys_addr     = 32'h0;
    sys_wen      = 1'b0;
    sys_ren      = 1'b0;
    region_rdata = '0;
    region_ack   = 6'h0;
    region_err   = 6'h0;
    region_irq   = 6'h0;
    {asg_a, asg_b, pid_a, pid_b} = '0;
    wait_reset_release(20);

    // random decode, response, irq and dac traffic
    for (int i = 0; i < 300; i++) begin
      rnd   = $random(seed);
      field = (rnd[7:4] == 4'h0) ? 10'h3ff : {6'h00, rnd[3:0]};  // some bank hits
      access(field, rnd[27:8], rnd[28], rnd[29]);
    end

    // every region including the free ones and unmatched fields
    for (int r = 0; r < 10; r++) access(10'(r), 20'h00010, 1'b1, 1'b1);
    access(10'h100, 20'h0, 1'b0, 1'b1);
    access(10'h3fe, 20'h0, 1'b1, 1'b0);

    // configuration bank offsets
    access(10'h3ff, 20'hf0000, 1'b0, 1'b1);
    access(10'h3ff, 20'hf0004, 1'b0, 1'b1);
    for (int r = 0; r < 10; r++) access(10'h3ff, 20'hf0100 + 20'(4 * r), 1'b0, 1'b1);
    access(10'h3ff, 20'hf0008, 1'b0, 1'b1);
    access(10'h3ff, 20'h00000, 1'b1, 1'b0);

    // dac extremes
    drive_dac(8191, 8191, -8192, -8192);
    drive_dac(8191, 1, -8192, -1);
    drive_dac(8191, -8192, 4096, 4095);
    drive_dac(4096, 4096, -4096, -4097);
    drive_dac(0, 0, -1, 1);
    drive_dac(0, 0, 0, 0);
    repeat (2) @(negedge adc_clk);  // let the last samples reach the outputs
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== rp_sysbus.f ====
rp_sysbus_pkg.sv
bus_decoder.sv
response_mux.sv
sysconf_rom.sv
irq_router.sv
dac_mixer.sv
rp_sysbus_top.sv
tb_clock_gen.sv
tb_rp_sysbus.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the testbench with Verilator.
# A failed build or run leaves the fail message in the log; the log decides.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_rp_sysbus \
  -f rp_sysbus.f -o tb_rp_sysbus > sim.log 2>&1 \
  && ./obj_dir/tb_rp_sysbus >> sim.log 2>&1 \
  || echo "RESULT: FAIL" >> sim.log

cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0
